// File: bench/minibyte_tests.svh
//----------------------------------------------------------------------
// Directed tests for the minibyte processor. Each task loads a short
// program under reset, runs it and checks the byte that it stores.
//----------------------------------------------------------------------

// Result of an ALU form, ADD and SUB wrap modulo 256
function automatic data_t expected_result(input opcode_t op, input data_t a, input data_t b);
    int r;
    case (op)
        ADD_IMM, ADD_DIR: r = (int'(a) + int'(b)) % 256;
        SUB_IMM, SUB_DIR: r = (int'(a) + 256 - int'(b)) % 256;
        AND_IMM, AND_DIR: r = int'(a & b);
        OR_IMM, OR_DIR:   r = int'(a | b);
        XOR_IMM, XOR_DIR: r = int'(a ^ b);
        default:          r = int'(b);
    endcase
    return data_t'(r);
endfunction

task automatic test_lda_sta_imm();
    data_t x;
    int    cycles;
    x = data_t'($urandom);
    hold_reset();
    put_byte(8'h00, data_t'(LDA_IMM));
    put_byte(8'h01, x);
    put_byte(8'h02, data_t'(STA_IMM));
    put_byte(8'h03, 8'h80);
    run_store("lda_sta_imm", 8'h80, x, cycles);
endtask

task automatic test_lda_dir();
    data_t y;
    int    cycles;
    y = data_t'($urandom);
    hold_reset();
    put_byte(8'h00, data_t'(LDA_DIR));
    put_byte(8'h01, 8'h90);
    put_byte(8'h02, data_t'(STA_IMM));
    put_byte(8'h03, 8'h81);
    put_byte(8'h90, y);
    run_store("lda_dir", 8'h81, y, cycles);
endtask

task automatic test_alu_imm();
    opcode_t ops [5];
    data_t   a;
    data_t   b;
    int      cycles;
    ops = '{ADD_IMM, SUB_IMM, AND_IMM, OR_IMM, XOR_IMM};
    foreach (ops[i]) begin
        a = data_t'($urandom);
        b = data_t'($urandom);
        hold_reset();
        put_byte(8'h00, data_t'(LDA_IMM));
        put_byte(8'h01, a);
        put_byte(8'h02, data_t'(ops[i]));
        put_byte(8'h03, b);
        put_byte(8'h04, data_t'(STA_IMM));
        put_byte(8'h05, 8'h82);
        run_store($sformatf("alu_imm op %0d", ops[i]), 8'h82,
                  expected_result(ops[i], a, b), cycles);
    end
endtask

task automatic test_alu_dir();
    opcode_t ops [5];
    data_t   a;
    data_t   b;
    int      cycles;
    ops = '{ADD_DIR, SUB_DIR, AND_DIR, OR_DIR, XOR_DIR};
    foreach (ops[i]) begin
        a = data_t'($urandom);
        b = data_t'($urandom);
        hold_reset();
        put_byte(8'h00, data_t'(LDA_IMM));
        put_byte(8'h01, a);
        put_byte(8'h02, data_t'(ops[i]));
        put_byte(8'h03, 8'ha0);
        put_byte(8'h04, data_t'(STA_IMM));
        put_byte(8'h05, 8'h83);
        // Operand lives away from the program
        put_byte(8'ha0, b);
        run_store($sformatf("alu_dir op %0d", ops[i]), 8'h83,
                  expected_result(ops[i], a, b), cycles);
    end
endtask

// Single-byte opcodes, so LDA must sit at address 3
task automatic test_nop_unknown();
    data_t z;
    int    cycles;
    z = data_t'($urandom);
    hold_reset();
    put_byte(8'h00, data_t'(NOP));
    put_byte(8'h01, 8'h04);
    put_byte(8'h02, 8'hee);
    put_byte(8'h03, data_t'(LDA_IMM));
    put_byte(8'h04, z);
    put_byte(8'h05, data_t'(STA_IMM));
    put_byte(8'h06, 8'h84);
    run_store("nop_unknown", 8'h84, z, cycles);
endtask

task automatic test_cycle_count();
    data_t x;
    int    cycles;
    int    expected;
    x = data_t'($urandom);
    hold_reset();
    put_byte(8'h00, data_t'(LDA_IMM));
    put_byte(8'h01, x);
    put_byte(8'h02, data_t'(STA_IMM));
    put_byte(8'h03, 8'h85);
    // RESET state, full LDA_IMM, then STA up to its first write cycle
    expected = 1 + 7 + (3 + 1 + 2 + 1);
    run_store("cycle_count", 8'h85, x, cycles);
    check_cycles("cycle_count", expected, cycles);
endtask

// File: bench/minibyte_tb.sv
//----------------------------------------------------------------------
// Testbench for the minibyte processor. Provides clock, reset, a
// 256-byte memory with combinational read, the DUT and the compare
// and wait tasks; the directed tests come from the included header.
//----------------------------------------------------------------------
module minibyte_tb
    import minibyte_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD    = 20;
    localparam int          WRITE_TIMEOUT = 200;
    localparam logic [31:0] SEED          = 32'h887e23c6;

    logic  clk_in;
    logic  rst_in;
    data_t mem_rdata;
    addr_t mem_addr;
    data_t mem_wdata;
    logic  mem_we;

    data_t mem [MEM_DEPTH];

    int error_count;
    int check_count;

    minibyte_top minibyte_top_inst (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    //------------------------------------------------------------------
    // Memory model, read in the same cycle, write on the edge
    //------------------------------------------------------------------
    assign mem_rdata = mem[mem_addr];

    always @(posedge clk_in) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // Background bytes, every address gets its own value
    task automatic fill_memory();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] <= data_t'(i) ^ 8'hc3;
        end
    endtask

    task automatic put_byte(input addr_t addr, input data_t value);
        mem[addr] <= value;
    endtask

    //------------------------------------------------------------------
    // Compare tasks
    //------------------------------------------------------------------
    task automatic check_data(input string name, input data_t expected, input data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: expected address %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("Fail %s: expected %0d cycles, actual %0d", name, expected, actual);
        end
    endtask

    //------------------------------------------------------------------
    // Reset and wait tasks
    //------------------------------------------------------------------
    // Reset low for two cycles, memory refilled while the DUT is idle
    task automatic hold_reset();
        @(posedge clk_in);
        rst_in <= 1'b0;
        @(posedge clk_in);
        fill_memory();
    endtask

    task automatic release_reset();
        @(posedge clk_in);
        rst_in <= 1'b1;
    endtask

    task automatic wait_write(output logic seen, output addr_t addr, output int cycles);
        seen   = 1'b0;
        addr   = '0;
        cycles = 0;
        while (!seen && cycles < WRITE_TIMEOUT) begin
            @(negedge clk_in);
            cycles++;
            if (mem_we) begin
                seen = 1'b1;
                addr = mem_addr;
            end
        end
    endtask

    // Runs the loaded program and checks its first store
    task automatic run_store(input string name, input addr_t exp_addr,
                             input data_t exp_data, output int cycles);
        logic  seen;
        addr_t addr;
        release_reset();
        wait_write(seen, addr, cycles);
        if (!seen) begin
            error_count++;
            $display("%s: no memory write within %0d cycles of reset release",
                     name, WRITE_TIMEOUT);
        end else begin
            check_addr(name, exp_addr, addr);
            // Let the write land in memory
            @(negedge clk_in);
            check_data(name, exp_data, mem[exp_addr]);
        end
    endtask

    `include "minibyte_tests.svh"

    initial begin
        rst_in      = 1'b0;
        error_count = 0;
        check_count = 0;
        void'($urandom(SEED));
        fill_memory();
        test_lda_sta_imm();
        test_lda_dir();
        test_alu_imm();
        test_alu_dir();
        test_nop_unknown();
        test_cycle_count();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: design/minibyte_alu.sv
//----------------------------------------------------------------------
// Combinational ALU. Operand a is the accumulator and b the memory
// read data; the result feeds the accumulator and the write data bus.
//----------------------------------------------------------------------
module minibyte_alu
    import minibyte_pkg::*;
(
    input  data_t   a,
    input  data_t   b,
    input  alu_op_t op,
    output data_t   result
);

    data_t sum;
    data_t diff;

    // Both wrap modulo 256
    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            PASS_A: begin
                result = a;
            end
            PASS_B: begin
                result = b;
            end
            ADD: begin
                result = sum;
            end
            SUB: begin
                result = diff;
            end
            AND: begin
                result = a & b;
            end
            OR: begin
                result = a | b;
            end
            XOR: begin
                result = a ^ b;
            end
            default: begin
                result = b;
            end
        endcase
    end

endmodule

// File: design/minibyte_control.sv
//----------------------------------------------------------------------
// Instruction sequencer. A registered state walks fetch, decode and
// one of the immediate, direct or store chains; each state maps to a
// fixed control word for the datapath. The ALU operation of the
// immediate and direct chains comes from the opcode held in IR.
//----------------------------------------------------------------------
module minibyte_control
    import minibyte_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_in,
    input  opcode_t ir_op,
    output ctrl_t   ctrl
);

    state_t  state;
    state_t  next_state;
    alu_op_t op_alu;

    // ALU operation of an LDA or ALU-form opcode
    function automatic alu_op_t alu_op_for(input opcode_t op);
        case (op)
            ADD_IMM, ADD_DIR: alu_op_for = ADD;
            SUB_IMM, SUB_DIR: alu_op_for = SUB;
            AND_IMM, AND_DIR: alu_op_for = AND;
            OR_IMM,  OR_DIR:  alu_op_for = OR;
            XOR_IMM, XOR_DIR: alu_op_for = XOR;
            default:          alu_op_for = PASS_B;
        endcase
    endfunction

    assign op_alu = alu_op_for(ir_op);

    //------------------------------------------------------------------
    // State register
    //------------------------------------------------------------------
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    //------------------------------------------------------------------
    // Next state
    //------------------------------------------------------------------
    always_comb begin
        case (state)
            RESET:   next_state = FETCH_0;
            PC_INC:  next_state = FETCH_0;
            FETCH_0: next_state = FETCH_1;
            FETCH_1: next_state = FETCH_2;
            FETCH_2: next_state = DECODE;
            DECODE: begin
                case (ir_op)
                    LDA_IMM, ADD_IMM, SUB_IMM, AND_IMM, OR_IMM, XOR_IMM: begin
                        next_state = OPER_0;
                    end
                    LDA_DIR, ADD_DIR, SUB_DIR, AND_DIR, OR_DIR, XOR_DIR: begin
                        next_state = DIR_0;
                    end
                    STA_IMM: begin
                        next_state = STA_0;
                    end
                    // NOP, STA_DIR and anything unknown
                    default: begin
                        next_state = FETCH_0;
                    end
                endcase
            end
            OPER_0:  next_state = OPER_1;
            OPER_1:  next_state = PC_INC;
            DIR_0:   next_state = DIR_1;
            DIR_1:   next_state = DIR_2;
            DIR_2:   next_state = DIR_3;
            DIR_3:   next_state = PC_INC;
            STA_0:   next_state = STA_1;
            STA_1:   next_state = STA_2;
            STA_2:   next_state = STA_3;
            STA_3:   next_state = PC_INC;
            default: next_state = PC_INC;
        endcase
    end

    //------------------------------------------------------------------
    // Control word per state
    //------------------------------------------------------------------
    always_comb begin
        ctrl = CTRL_IDLE;
        case (state)
            PC_INC: begin
                ctrl.inc_pc = 1'b1;
            end
            FETCH_1: begin
                ctrl.set_ir = 1'b1;
            end
            FETCH_2: begin
                ctrl.inc_pc = 1'b1;
            end
            // Immediate operand sits at PC
            OPER_0: begin
                ctrl.alu_op = op_alu;
            end
            OPER_1: begin
                ctrl.alu_op = op_alu;
                ctrl.set_a  = 1'b1;
            end
            // Operand byte is an address, latch it in M
            DIR_1: begin
                ctrl.set_m = 1'b1;
            end
            DIR_2: begin
                ctrl.addr_sel = SEL_M;
                ctrl.alu_op   = op_alu;
            end
            DIR_3: begin
                ctrl.addr_sel = SEL_M;
                ctrl.alu_op   = op_alu;
                ctrl.set_a    = 1'b1;
            end
            STA_1: begin
                ctrl.set_m = 1'b1;
            end
            // Store A at M, held for two cycles
            STA_2, STA_3: begin
                ctrl.addr_sel = SEL_M;
                ctrl.alu_op   = PASS_A;
                ctrl.write    = 1'b1;
            end
            default: begin
                ctrl = CTRL_IDLE;
            end
        endcase
    end

    //------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------
    a_write_at_m: assert property (
        @(posedge clk_in) disable iff (!rst_in)
        ctrl.write |-> ctrl.addr_sel == SEL_M
    ) else $error("write strobe with PC on the address");

endmodule

// File: design/minibyte_datapath.sv
//----------------------------------------------------------------------
// Datapath with the accumulator A, address register M, program
// counter PC and instruction register IR. Drives the memory bus from
// the control word; read data must be valid in the same cycle.
//----------------------------------------------------------------------
module minibyte_datapath
    import minibyte_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_in,
    input  ctrl_t   ctrl,
    input  data_t   mem_rdata,
    output opcode_t ir_op,
    output addr_t   mem_addr,
    output data_t   mem_wdata,
    output logic    mem_we
);

    data_t a_q;
    addr_t m_q;
    addr_t pc_q;
    data_t ir_q;
    data_t alu_result;

    //------------------------------------------------------------------
    // ALU, memory data on the b side
    //------------------------------------------------------------------
    minibyte_alu minibyte_alu_inst (
        .a      (a_q),
        .b      (mem_rdata),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    // Accumulator
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            a_q <= '0;
        end else if (ctrl.set_a) begin
            a_q <= alu_result;
        end
    end

    // Address register, loaded from an operand byte
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            m_q <= '0;
        end else if (ctrl.set_m) begin
            m_q <= addr_t'(mem_rdata);
        end
    end

    // Program counter
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            pc_q <= RESET_PC;
        end else if (ctrl.inc_pc) begin
            pc_q <= pc_q + addr_t'(1);
        end
    end

    // Instruction register
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            ir_q <= '0;
        end else if (ctrl.set_ir) begin
            ir_q <= mem_rdata;
        end
    end

    // Unknown codes pass through and decode as NOP
    assign ir_op = opcode_t'(ir_q);

    //------------------------------------------------------------------
    // Memory bus
    //------------------------------------------------------------------
    assign mem_addr  = (ctrl.addr_sel == SEL_M) ? m_q : pc_q;
    assign mem_wdata = alu_result;
    assign mem_we    = ctrl.write;

    a_single_load: assert property (
        @(posedge clk_in) disable iff (!rst_in)
        !(ctrl.set_a && ctrl.set_m)
    ) else $error("A and M loaded in the same cycle");

endmodule

// File: design/minibyte_pkg.sv
//----------------------------------------------------------------------
// Shared types and constants for the minibyte accumulator processor.
// Holds the bus widths, the opcode map, the sequencer states, the ALU
// operations and the control word passed from sequencer to datapath.
// Modules pull these in with a wildcard import in their header.
//----------------------------------------------------------------------
package minibyte_pkg;

    // Bus sizes
    localparam int DATA_W    = 8;
    localparam int ADDR_W    = 8;
    localparam int MEM_DEPTH = 256;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // First instruction fetched after reset
    localparam addr_t RESET_PC = 8'h00;

    //------------------------------------------------------------------
    // Instruction codes
    //------------------------------------------------------------------
    typedef enum logic [7:0] {
        NOP     = 8'd0,
        LDA_IMM = 8'd1,
        LDA_DIR = 8'd2,
        STA_IMM = 8'd3,
        STA_DIR = 8'd4,
        ADD_IMM = 8'd5,
        ADD_DIR = 8'd6,
        SUB_IMM = 8'd7,
        SUB_DIR = 8'd8,
        AND_IMM = 8'd9,
        AND_DIR = 8'd10,
        OR_IMM  = 8'd11,
        OR_DIR  = 8'd12,
        XOR_IMM = 8'd13,
        XOR_DIR = 8'd14
    } opcode_t;

    // ALU operation select
    typedef enum logic [2:0] {
        PASS_A = 3'd0,
        PASS_B = 3'd1,
        ADD    = 3'd2,
        SUB    = 3'd3,
        AND    = 3'd4,
        OR     = 3'd5,
        XOR    = 3'd6
    } alu_op_t;

    // Memory address source
    typedef enum logic {
        SEL_PC = 1'b0,
        SEL_M  = 1'b1
    } addr_sel_t;

    //------------------------------------------------------------------
    // Sequencer states
    //------------------------------------------------------------------
    typedef enum logic [3:0] {
        RESET, PC_INC,
        FETCH_0, FETCH_1, FETCH_2, DECODE,
        OPER_0, OPER_1,
        DIR_0, DIR_1, DIR_2, DIR_3,
        STA_0, STA_1, STA_2, STA_3
    } state_t;

    // Control word, one per sequencer state
    typedef struct packed {
        logic      set_a;
        logic      set_m;
        logic      set_ir;
        logic      inc_pc;
        addr_sel_t addr_sel;
        alu_op_t   alu_op;
        logic      write;
    } ctrl_t;

    // No strobes, PC on the address, memory data through the ALU
    localparam ctrl_t CTRL_IDLE = '{
        set_a: 1'b0, set_m: 1'b0, set_ir: 1'b0, inc_pc: 1'b0,
        addr_sel: SEL_PC, alu_op: PASS_B, write: 1'b0
    };

endpackage

// File: design/minibyte_top.sv
//----------------------------------------------------------------------
// Processor top level. Joins the sequencer to the datapath and brings
// out the single-cycle memory bus; memory sits outside this block.
//----------------------------------------------------------------------
module minibyte_top
    import minibyte_pkg::*;
(
    input  logic  clk_in,
    input  logic  rst_in,
    input  data_t mem_rdata,
    output addr_t mem_addr,
    output data_t mem_wdata,
    output logic  mem_we
);

    ctrl_t   ctrl;
    opcode_t ir_op;

    // Sequencer
    minibyte_control minibyte_control_inst (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .ir_op  (ir_op),
        .ctrl   (ctrl)
    );

    // Registers, ALU and bus drivers
    minibyte_datapath minibyte_datapath_inst (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .ir_op     (ir_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we)
    );

endmodule

// File: verilog.f
+incdir+bench
design/minibyte_pkg.sv
design/minibyte_alu.sv
design/minibyte_control.sv
design/minibyte_datapath.sv
design/minibyte_top.sv
bench/minibyte_tb.sv
